/* logic/eth_measurer_consts.svh */
// Latency measurer constants for payload size, id length and the lost leg marker
`ifndef ETH_MEASURER_CONSTS_SVH
`define ETH_MEASURER_CONSTS_SVH

// Smallest Ethernet payload, used as the latched size after reset
`define ETH_MIN_PAYLOAD 16'd46

// Ping id field length in bytes, also the shortest frame
`define PING_ID_BYTES 16'd8

// Leg time reported for a lost ping or pong
`define TIME_LOST 32'hFFFF_FFFF

`endif

/* logic/eth_measurer_pkg.sv */
// Latency measurer package holding the coordinator states and the shared stream and result types
package eth_measurer_pkg;

	// Coordinator sequence, one exchange runs through all five states
	typedef enum logic [2:0] {
		ST_DELAY,
		ST_WAIT_PING_TX,
		ST_PING,
		ST_WAIT_PONG_TX,
		ST_PONG
	} coord_state_t;

	// One byte of a frame, last marks the final byte
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
		logic       last;
	} byte_stream_t;

	// Run configuration from outside
	typedef struct packed {
		logic [15:0] psize_req;   // Requested payload bytes
		logic [31:0] delay_time;  // Idle cycles between exchanges
		logic [31:0] timeout;     // Per leg timeout in cycles
	} meas_config_t;

	// Leg times of the last exchange
	typedef struct packed {
		logic [31:0] ping_time;
		logic [31:0] pong_time;
	} meas_result_t;

	// Running exchange statistics
	typedef struct packed {
		logic [63:0] ping_pongs_good;
		logic [63:0] pings_lost;
		logic [63:0] pongs_lost;
	} meas_stats_t;

endpackage

/* logic/eth_interval_timer.sv */
// Interval timer counting cycles with clear, start at one and a limit reached flag
`timescale 1ns/1ps

module eth_interval_timer (
	input  logic        clk,
	input  logic        rst,
	input  logic        clear,
	input  logic        start,
	input  logic [31:0] limit,
	output logic [31:0] count,
	output logic        reached
);

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= 32'd0;
		end else if (clear) begin
			count <= 32'd0;
		end else if (start) begin
			count <= 32'd1;
		end else begin
			count <= count + 32'd1; // Free running, wraps after 2^32 cycles
		end
	end

	// A zero limit is reached at once, otherwise one cycle early so that the
	// registered decision lands exactly on the limit
	always_comb begin
		if (limit == 32'd0) begin
			reached = 1'b1;
		end else begin
			reached = (count >= limit - 32'd1);
		end
	end

endmodule

/* logic/eth_ping_tx.sv */
// Ping frame sender streaming the 64-bit id and then counting filler bytes
`timescale 1ns/1ps
`include "eth_measurer_consts.svh"

module eth_ping_tx (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          trigger,
	input  logic [63:0]                   ping_id,
	input  logic [15:0]                   psize,
	output eth_measurer_pkg::byte_stream_t tx,
	output logic                          tx_begin
);
	logic        busy;
	logic [15:0] idx;     // Bytes already sent in this frame
	logic [15:0] len;
	logic [63:0] id_sh;
	logic [7:0]  fill;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			tx <= '0;
			tx_begin <= 1'b0;
		end else begin
			tx_begin <= 1'b0;
			if (!busy) begin
				tx <= '0;
				if (trigger) begin
					busy <= 1'b1;
					tx_begin <= 1'b1;
					tx.valid <= 1'b1;
					tx.data <= ping_id[63:56]; // Most significant id byte leads
					tx.last <= 1'b0;
				end
			end else if (tx.last) begin
				busy <= 1'b0;
				tx <= '0;
			end else begin
				tx.valid <= 1'b1;
				tx.last <= (idx == len - 16'd1);
				if (idx < `PING_ID_BYTES) begin
					tx.data <= id_sh[63:56];
				end else begin
					tx.data <= fill;
				end
			end
		end
	end

	// Frame payload bookkeeping
	always_ff @(posedge clk) begin
		if (!busy && trigger) begin
			id_sh <= {ping_id[55:0], 8'h00};
			len <= (psize < `PING_ID_BYTES) ? `PING_ID_BYTES : psize;
			idx <= 16'd1;
			fill <= 8'd0;
		end else if (busy && !tx.last) begin
			idx <= idx + 16'd1;
			if (idx < `PING_ID_BYTES) begin
				id_sh <= {id_sh[55:0], 8'h00};
			end else begin
				fill <= fill + 8'd1;
			end
		end
	end

endmodule

/* logic/eth_ping_rx.sv */
// Ping frame parser assembling the id from the first eight bytes of each frame
`timescale 1ns/1ps
`include "eth_measurer_consts.svh"

module eth_ping_rx (
	input  logic                          clk,
	input  logic                          rst,
	input  eth_measurer_pkg::byte_stream_t rx,
	output logic [63:0]                   rx_ping_id
);
	logic [3:0]  cnt;       // Saturates once the id field is complete
	logic [63:0] hold;
	logic [63:0] hold_next;

	// The eighth byte may be the last one, so publish from the shifted value
	always_comb begin
		if (cnt < `PING_ID_BYTES) begin
			hold_next = {hold[55:0], rx.data};
		end else begin
			hold_next = hold;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= 4'd0;
			rx_ping_id <= '1; // Cannot equal the first ping id
		end else if (rx.valid) begin
			if (rx.last) begin
				cnt <= 4'd0;
				if (cnt >= `PING_ID_BYTES - 16'd1) begin
					rx_ping_id <= hold_next;
				end
				// Shorter frames leave the id untouched
			end else if (cnt < `PING_ID_BYTES) begin
				cnt <= cnt + 4'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx.valid) begin
			hold <= hold_next;
		end
	end

endmodule

/* logic/eth_measurer_coord.sv */
// Measurement coordinator that sequences delay, ping and pong legs and keeps the statistics
`timescale 1ns/1ps
`include "eth_measurer_consts.svh"

module eth_measurer_coord (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          enable,
	input  eth_measurer_pkg::meas_config_t cfg,

	input  logic [31:0]                   count,
	input  logic                          reached,
	output logic                          timer_clear,
	output logic                          timer_start,
	output logic [31:0]                   timer_limit,

	input  logic                          main_tx_begin,
	input  logic                          loop_tx_begin,
	input  logic [63:0]                   main_rx_ping_id,
	input  logic [63:0]                   loop_rx_ping_id,

	output logic [15:0]                   psize,
	output logic [63:0]                   ping_id,
	output logic                          main_tx_trigger,
	output logic                          loop_tx_trigger,

	output logic                          done,
	output eth_measurer_pkg::meas_result_t result,
	output eth_measurer_pkg::meas_stats_t  stats
);
	eth_measurer_pkg::coord_state_t state, state_next;

	logic [15:0] psize_next;
	logic [63:0] ping_id_next;
	logic main_tx_trigger_next, loop_tx_trigger_next;
	logic done_next;
	eth_measurer_pkg::meas_result_t result_next;
	eth_measurer_pkg::meas_stats_t stats_next;

	// The delay state waits on delay_time, every other state runs against the timeout
	assign timer_limit = (state == eth_measurer_pkg::ST_DELAY) ? cfg.delay_time : cfg.timeout;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= eth_measurer_pkg::ST_DELAY;
			ping_id <= 64'd0;
			psize <= `ETH_MIN_PAYLOAD;
			main_tx_trigger <= 1'b0;
			loop_tx_trigger <= 1'b0;
			done <= 1'b0;
			result <= '0;
			stats <= '0;
		end else begin
			state <= state_next;
			ping_id <= ping_id_next;
			psize <= psize_next;
			main_tx_trigger <= main_tx_trigger_next;
			loop_tx_trigger <= loop_tx_trigger_next;
			done <= done_next;
			result <= result_next;
			stats <= stats_next;
		end
	end

	always_comb begin
		state_next = state;
		ping_id_next = ping_id;
		psize_next = psize;
		main_tx_trigger_next = 1'b0;
		loop_tx_trigger_next = 1'b0;
		done_next = 1'b0;
		result_next = result;
		stats_next = stats;
		timer_clear = 1'b0;
		timer_start = 1'b0;

		case (state)
			eth_measurer_pkg::ST_DELAY: begin
				if (!enable) begin
					timer_clear = 1'b1; // Delay restarts once enable returns
				end else if (reached) begin
					state_next = eth_measurer_pkg::ST_WAIT_PING_TX;
					timer_clear = 1'b1;
					psize_next = cfg.psize_req;
					main_tx_trigger_next = 1'b1;
				end
			end

			eth_measurer_pkg::ST_WAIT_PING_TX: begin
				if (main_tx_begin) begin
					state_next = eth_measurer_pkg::ST_PING;
					timer_start = 1'b1; // First byte cycle counts as one
				end
			end

			eth_measurer_pkg::ST_PING: begin
				if (loop_rx_ping_id == ping_id) begin
					state_next = eth_measurer_pkg::ST_WAIT_PONG_TX;
					timer_clear = 1'b1;
					result_next.ping_time = count + 32'd1;
					loop_tx_trigger_next = 1'b1; // Loopback side answers with the pong
				end else if (reached) begin
					// Ping never reached the loopback port, same id is retried
					state_next = eth_measurer_pkg::ST_DELAY;
					timer_clear = 1'b1;
					done_next = 1'b1;
					result_next.ping_time = `TIME_LOST;
					result_next.pong_time = `TIME_LOST;
					stats_next.pings_lost = stats.pings_lost + 64'd1;
				end
			end

			eth_measurer_pkg::ST_WAIT_PONG_TX: begin
				if (loop_tx_begin) begin
					state_next = eth_measurer_pkg::ST_PONG;
					timer_start = 1'b1;
				end
			end

			eth_measurer_pkg::ST_PONG: begin
				if (main_rx_ping_id == ping_id) begin
					state_next = eth_measurer_pkg::ST_DELAY;
					timer_clear = 1'b1;
					done_next = 1'b1;
					ping_id_next = ping_id + 64'd1;
					result_next.pong_time = count + 32'd1;
					stats_next.ping_pongs_good = stats.ping_pongs_good + 64'd1;
				end else if (reached) begin
					state_next = eth_measurer_pkg::ST_DELAY; // Pong lost on the way back
					timer_clear = 1'b1;
					done_next = 1'b1;
					ping_id_next = ping_id + 64'd1;
					result_next.pong_time = `TIME_LOST;
					stats_next.pongs_lost = stats.pongs_lost + 64'd1;
				end
			end

			default: begin
				state_next = eth_measurer_pkg::ST_DELAY;
			end
		endcase
	end

endmodule

/* logic/eth_measurer_top.sv */
// Latency measurer top joining the coordinator, interval timer, two senders and two parsers
`timescale 1ns/1ps

module eth_measurer_top (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          enable,
	input  eth_measurer_pkg::meas_config_t cfg,
	output eth_measurer_pkg::byte_stream_t main_tx,
	output eth_measurer_pkg::byte_stream_t loop_tx,
	input  eth_measurer_pkg::byte_stream_t main_rx,
	input  eth_measurer_pkg::byte_stream_t loop_rx,
	output logic                          done,
	output eth_measurer_pkg::meas_result_t result,
	output eth_measurer_pkg::meas_stats_t  stats
);
	logic        timer_clear;
	logic        timer_start;
	logic [31:0] timer_limit;
	logic [31:0] count;
	logic        reached;

	logic [63:0] ping_id;
	logic [15:0] psize;
	logic        main_tx_trigger, loop_tx_trigger;
	logic        main_tx_begin, loop_tx_begin;
	logic [63:0] main_rx_ping_id, loop_rx_ping_id;

	eth_measurer_coord i_coord (
		.clk             (clk),
		.rst             (rst),
		.enable          (enable),
		.cfg             (cfg),
		.count           (count),
		.reached         (reached),
		.timer_clear     (timer_clear),
		.timer_start     (timer_start),
		.timer_limit     (timer_limit),
		.main_tx_begin   (main_tx_begin),
		.loop_tx_begin   (loop_tx_begin),
		.main_rx_ping_id (main_rx_ping_id),
		.loop_rx_ping_id (loop_rx_ping_id),
		.psize           (psize),
		.ping_id         (ping_id),
		.main_tx_trigger (main_tx_trigger),
		.loop_tx_trigger (loop_tx_trigger),
		.done            (done),
		.result          (result),
		.stats           (stats)
	);

	eth_interval_timer i_timer (
		.clk     (clk),
		.rst     (rst),
		.clear   (timer_clear),
		.start   (timer_start),
		.limit   (timer_limit),
		.count   (count),
		.reached (reached)
	);

	// Main port sends the ping, loopback port answers with the same id
	eth_ping_tx i_main_tx (
		.clk      (clk),
		.rst      (rst),
		.trigger  (main_tx_trigger),
		.ping_id  (ping_id),
		.psize    (psize),
		.tx       (main_tx),
		.tx_begin (main_tx_begin)
	);

	eth_ping_tx i_loop_tx (
		.clk      (clk),
		.rst      (rst),
		.trigger  (loop_tx_trigger),
		.ping_id  (ping_id),
		.psize    (psize),
		.tx       (loop_tx),
		.tx_begin (loop_tx_begin)
	);

	eth_ping_rx i_main_rx (
		.clk        (clk),
		.rst        (rst),
		.rx         (main_rx),
		.rx_ping_id (main_rx_ping_id)
	);

	eth_ping_rx i_loop_rx (
		.clk        (clk),
		.rst        (rst),
		.rx         (loop_rx),
		.rx_ping_id (loop_rx_ping_id)
	);

endmodule

/* tests/tb_clock.sv */
// Testbench clock and reset generator with a 10 ns period and a ten cycle reset
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Reset leaves on a falling edge like every other input
	initial begin
		rst = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

/* tests/eth_link_model.sv */
// Testbench network that forwards both port streams through fixed delay lines with frame drops
`timescale 1ns/1ps

module frame_delay_line #(
	parameter int DEPTH = 4
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           drop,
	input  eth_measurer_pkg::byte_stream_t upstream,
	output eth_measurer_pkg::byte_stream_t downstream
);
	eth_measurer_pkg::byte_stream_t line [DEPTH];
	logic in_frame;
	logic dropping;
	logic suppress;

	// The drop decision is taken on the first byte and held for the whole frame
	assign suppress = upstream.valid && (in_frame ? dropping : drop);

	always_ff @(posedge clk) begin
		if (rst) begin
			in_frame <= 1'b0;
			dropping <= 1'b0;
			for (int i = 0; i < DEPTH; i++) begin
				line[i] <= '0;
			end
		end else begin
			if (upstream.valid) begin
				if (!in_frame) begin
					dropping <= drop;
				end
				in_frame <= !upstream.last;
			end
			line[0] <= suppress ? '0 : upstream;
			for (int i = 1; i < DEPTH; i++) begin
				line[i] <= line[i - 1];
			end
		end
	end

	assign downstream = rst ? '0 : line[DEPTH - 1]; // Idle while the line is being reset

endmodule

module eth_link_model #(
	parameter int LINK_DELAY = 4
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           drop_ping,
	input  logic                           drop_pong,
	input  eth_measurer_pkg::byte_stream_t main_tx,
	input  eth_measurer_pkg::byte_stream_t loop_tx,
	output eth_measurer_pkg::byte_stream_t main_rx,
	output eth_measurer_pkg::byte_stream_t loop_rx
);

	frame_delay_line #(.DEPTH(LINK_DELAY)) i_ping_path (
		.clk        (clk),
		.rst        (rst),
		.drop       (drop_ping),
		.upstream   (main_tx),
		.downstream (loop_rx)
	);

	frame_delay_line #(.DEPTH(LINK_DELAY)) i_pong_path (
		.clk        (clk),
		.rst        (rst),
		.drop       (drop_pong),
		.upstream   (loop_tx),
		.downstream (main_rx)
	);

endmodule

/* tests/eth_measurer_tb.sv */
// Latency measurer testbench running directed exchange tests against a delayed link model
`timescale 1ns/1ps
`include "eth_measurer_consts.svh"

module eth_measurer_tb;
	localparam int LINK_DELAY = 5;
	localparam int DELAY_TIME = 20;
	localparam int TIMEOUT = 400;
	localparam int MAX_PSIZE = 200;
	localparam int NUM_TESTS = 6;
	localparam int MAX_EXCHANGES = 6;  // Most exchanges run by a single test
	localparam int EXCHANGE_CYCLES = DELAY_TIME + 2 * TIMEOUT + 2 * MAX_PSIZE;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * MAX_EXCHANGES * EXCHANGE_CYCLES + 100;

	logic clk;
	logic rst;
	logic enable;
	logic drop_ping;
	logic drop_pong;
	logic done;
	eth_measurer_pkg::meas_config_t cfg;
	eth_measurer_pkg::byte_stream_t main_tx, loop_tx, main_rx, loop_rx;
	eth_measurer_pkg::meas_result_t result;
	eth_measurer_pkg::meas_stats_t  stats;

	int done_count = 0;
	int main_frames = 0;
	int loop_frames = 0;
	int main_valid_bytes = 0;
	eth_measurer_pkg::meas_result_t done_result;
	logic [7:0] main_building[$];
	logic [7:0] main_frame[$];    // Most recent complete ping frame

	int checks = 0;
	int errors = 0;
	int tests_failed = 0;
	logic [63:0] exp_id = 64'd0;
	logic [63:0] exp_good = 64'd0;
	logic [63:0] exp_ping_lost = 64'd0;
	logic [63:0] exp_pong_lost = 64'd0;
	logic [31:0] lcg_state = 32'h66a5_ae83;

	tb_clock i_clock (.clk(clk), .rst(rst));

	eth_measurer_top i_dut (
		.clk     (clk),
		.rst     (rst),
		.enable  (enable),
		.cfg     (cfg),
		.main_tx (main_tx),
		.loop_tx (loop_tx),
		.main_rx (main_rx),
		.loop_rx (loop_rx),
		.done    (done),
		.result  (result),
		.stats   (stats)
	);

	eth_link_model #(.LINK_DELAY(LINK_DELAY)) i_link (
		.clk       (clk),
		.rst       (rst),
		.drop_ping (drop_ping),
		.drop_pong (drop_pong),
		.main_tx   (main_tx),
		.loop_tx   (loop_tx),
		.main_rx   (main_rx),
		.loop_rx   (loop_rx)
	);

	// Monitors see the values of the cycle that ends at this edge
	always @(posedge clk) begin
		if (!rst) begin
			if (done) begin
				done_count++;
				done_result = result;
			end
			if (main_tx.valid) begin
				main_valid_bytes++;
				main_building.push_back(main_tx.data);
				if (main_tx.last) begin
					main_frame = main_building;
					main_building.delete();
					main_frames++;
				end
			end
			if (loop_tx.valid && loop_tx.last) begin
				loop_frames++;
			end
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("CHECK FAILED %s: actual 0x%h expected 0x%h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic wait_for_done(input int start_count, output bit seen);
		int n;
		n = 0;
		seen = 1'b0;
		while (!seen && n < EXCHANGE_CYCLES) begin
			@(negedge clk);
			n++;
			if (done_count != start_count) begin
				seen = 1'b1;
			end
		end
		if (!seen) begin
			$display("No done pulse within %0d cycles of the exchange start", n);
			errors++;
		end
	endtask

	// Id most significant byte first, then filler counting up from zero
	task automatic check_frame(input int size, input logic [63:0] id);
		logic [7:0] exp_byte;
		check_value("main_tx frame length", 64'(main_frame.size()), 64'(size));
		for (int i = 0; i < main_frame.size(); i++) begin
			if (i < 8) begin
				exp_byte = id[63 - 8 * i -: 8];
			end else begin
				exp_byte = 8'(i - 8);
			end
			check_value($sformatf("main_tx.data byte %0d", i), 64'(main_frame[i]),
				64'(exp_byte));
		end
	endtask

	task automatic do_exchange(input int size, input bit lose_ping, input bit lose_pong);
		int done_start;
		int main_start;
		int loop_start;
		int leg;
		bit seen;
		done_start = done_count;
		main_start = main_frames;
		loop_start = loop_frames;
		leg = size + LINK_DELAY + 1; // Cycles from tx begin to the match with both ends counted
		cfg.psize_req = 16'(size);
		drop_ping = lose_ping;
		drop_pong = lose_pong;
		wait_for_done(done_start, seen);
		drop_ping = 1'b0;
		drop_pong = 1'b0;
		if (seen) begin
			check_value("main_tx frame count", 64'(main_frames), 64'(main_start + 1));
			check_frame(size, exp_id);
			if (lose_ping) begin
				exp_ping_lost++;
				check_value("loop_tx frame count", 64'(loop_frames), 64'(loop_start));
				check_value("result.ping_time", 64'(done_result.ping_time), 64'(`TIME_LOST));
				check_value("result.pong_time", 64'(done_result.pong_time), 64'(`TIME_LOST));
			end else begin
				check_value("loop_tx frame count", 64'(loop_frames), 64'(loop_start + 1));
				check_value("result.ping_time", 64'(done_result.ping_time), 64'(leg));
				check_value("ping_time below timeout", 64'(done_result.ping_time < TIMEOUT),
					64'd1);
				if (lose_pong) begin
					exp_pong_lost++;
					check_value("result.pong_time", 64'(done_result.pong_time),
						64'(`TIME_LOST));
				end else begin
					exp_good++;
					check_value("result.pong_time", 64'(done_result.pong_time), 64'(leg));
					check_value("pong_time below timeout",
						64'(done_result.pong_time < TIMEOUT), 64'd1);
				end
				exp_id++;
			end
			check_value("stats.ping_pongs_good", stats.ping_pongs_good, exp_good);
			check_value("stats.pings_lost", stats.pings_lost, exp_ping_lost);
			check_value("stats.pongs_lost", stats.pongs_lost, exp_pong_lost);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("Test %s ok", name);
		end else begin
			$display("Test %s failed with %0d errors", name, errors - errors_before);
			tests_failed++;
		end
	endtask

	task automatic test_good_exchange();
		int errors_before;
		errors_before = errors;
		do_exchange(46, 1'b0, 1'b0);
		report_test("good_exchange", errors_before);
	endtask

	task automatic test_frame_contents();
		int errors_before;
		errors_before = errors;
		do_exchange(50, 1'b0, 1'b0);
		do_exchange(120, 1'b0, 1'b0);
		do_exchange(MAX_PSIZE, 1'b0, 1'b0);
		report_test("frame_contents", errors_before);
	endtask

	task automatic test_lost_ping();
		int errors_before;
		errors_before = errors;
		do_exchange(80, 1'b1, 1'b0);
		do_exchange(80, 1'b0, 1'b0); // Retries the id of the lost ping
		report_test("lost_ping", errors_before);
	endtask

	task automatic test_lost_pong();
		int errors_before;
		errors_before = errors;
		do_exchange(90, 1'b0, 1'b1);
		do_exchange(90, 1'b0, 1'b0);
		report_test("lost_pong", errors_before);
	endtask

	task automatic test_enable_low();
		int errors_before;
		int bytes_before;
		int done_before;
		eth_measurer_pkg::meas_stats_t stats_before;
		errors_before = errors;
		enable = 1'b0;
		bytes_before = main_valid_bytes;
		done_before = done_count;
		stats_before = stats;
		// The window outlasts the delay and a whole exchange
		repeat (EXCHANGE_CYCLES) @(negedge clk);
		check_value("main_tx valid bytes", 64'(main_valid_bytes), 64'(bytes_before));
		check_value("done pulses", 64'(done_count), 64'(done_before));
		check_value("stats.ping_pongs_good", stats.ping_pongs_good, stats_before.ping_pongs_good);
		check_value("stats.pings_lost", stats.pings_lost, stats_before.pings_lost);
		check_value("stats.pongs_lost", stats.pongs_lost, stats_before.pongs_lost);
		enable = 1'b1;
		do_exchange(64, 1'b0, 1'b0);
		report_test("enable_low", errors_before);
	endtask

	task automatic test_random_sizes();
		int errors_before;
		int size;
		errors_before = errors;
		for (int n = 0; n < MAX_EXCHANGES; n++) begin
			lcg_state = lcg_next(lcg_state);
			size = 46 + int'((lcg_state >> 8) % 32'd155);
			do_exchange(size, 1'b0, 1'b0);
		end
		check_value("stats counter sum",
			stats.ping_pongs_good + stats.pings_lost + stats.pongs_lost, 64'(done_count));
		report_test("random_sizes", errors_before);
	endtask

	initial begin
		enable = 1'b0;
		drop_ping = 1'b0;
		drop_pong = 1'b0;
		cfg.psize_req = 16'd46;
		cfg.delay_time = DELAY_TIME;
		cfg.timeout = TIMEOUT;
		wait (rst === 1'b0);
		@(negedge clk);
		enable = 1'b1;
		test_good_exchange();
		test_frame_contents();
		test_lost_ping();
		test_lost_pong();
		test_enable_low();
		test_random_sizes();
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			NUM_TESTS, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
		$display("Regression failed");
		$finish;
	end

endmodule

/* eth_measurer.f */
+incdir+logic
logic/eth_measurer_pkg.sv
logic/eth_interval_timer.sv
logic/eth_ping_tx.sv
logic/eth_ping_rx.sv
logic/eth_measurer_coord.sv
logic/eth_measurer_top.sv
tests/tb_clock.sv
tests/eth_link_model.sv
tests/eth_measurer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the latency measurer testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module eth_measurer_tb \
	--Mdir obj_dir -o eth_measurer_sim \
	-f eth_measurer.f

./obj_dir/eth_measurer_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0
